//--- tb/mcu_command_patterns.txt
// per test: ncmd cmd_bytes.. systime nring ring_bytes.. nfifo fifo_lengths.. gpio
// all words hex, the first word is the number of tests.
11
01 00 00000000 04 00 c8 e8 56 01 04 00 // get_version
01 02 00000005 02 01 05 01 02 00 // get_time, 1 byte
01 02 ffffffff 02 01 7f 01 02 00 // get_time -1
01 02 00002fff 03 01 df 7f 01 03 00 // get_time, 2 bytes max
01 02 fffff000 03 01 e0 00 01 03 00 // get_time, 2 bytes min
01 02 0017ffff 04 01 df ff 7f 01 04 00 // get_time, 3 bytes max
01 02 fff80000 04 01 e0 80 00 01 04 00 // get_time, 3 bytes min
01 02 fc000000 05 01 e0 80 80 00 01 05 00 // get_time, 4 bytes min
01 02 7fffffff 06 01 87 ff ff ff 7f 01 06 00 // get_time, 5 bytes max
01 02 80000000 06 01 f8 80 80 80 00 01 06 00 // get_time, 5 bytes min
03 10 03 01 00000000 00 00 08 // config pin 3 default 1
04 0f 80 05 61 00000000 00 00 28 // set pin 5 (two bytes) to -31
03 0f 7e 01 00000000 00 00 68 // set pin -2 (pin 6) to 1
04 0f 7e 82 00 00000000 00 00 28 // set pin 6 to 256
01 13 00000000 00 00 08 // shutdown restores defaults
03 0f 01 01 00000000 00 00 08 // set ignored after shutdown
02 07 00 00000000 04 00 c8 e8 56 01 04 08 // unknown id, then get_version

//--- build.f
+incdir+logic
logic/mcu_cmd_pkg.sv
logic/vlq_decoder.sv
logic/cmd_dispatch.sv
logic/vlq_encoder.sv
logic/system_unit.sv
logic/gpio_unit.sv
logic/mcu_command.sv
tb/mcu_command_sva.sv
tb/mcu_command_tb.sv

//--- Bender.yml
package:
  name: mcu_command

sources:
  - include_dirs:
      - logic
    files:
      - logic/mcu_cmd_pkg.sv
      - logic/vlq_decoder.sv
      - logic/cmd_dispatch.sv
      - logic/vlq_encoder.sv
      - logic/system_unit.sv
      - logic/gpio_unit.sv
      - logic/mcu_command.sv
  - target: test
    files:
      - tb/mcu_command_sva.sv
      - tb/mcu_command_tb.sv

//--- tb/mcu_command_tb.sv
`timescale 1ns/1ns

module mcu_command_tb;
	import mcu_cmd_pkg::*;

	logic clk;
	logic rst_n;
	byte_t msg_data;
	logic msg_ready;
	logic msg_rd_en;
	byte_t send_ring_data;
	logic send_ring_wr_en;
	rsp_len_t send_fifo_data;
	logic send_fifo_wr_en;
	arg_t systime;
	gpio_t gpio;

	logic [31:0] pat [0:511]; // test records as laid out in the pattern file.
	byte_t ring_q [$];
	rsp_len_t fifo_q [$];
	int errors;
	int failed;
	int limit_cycles;

	mcu_command i_dut (.*);

	bind mcu_command mcu_command_sva u_sva (.*);

	always #50 clk = ~clk;

	// host side of the send ring and send fifo.
	always @(negedge clk) begin
		if (rst_n && send_ring_wr_en)
			ring_q.push_back(send_ring_data);
		if (rst_n && send_fifo_wr_en)
			fifo_q.push_back(send_fifo_data);
	end

	// each byte is held until msg_rd_en shows it was taken.
	task automatic send_bytes(input int base, input int count);
		int k;
		int gap;
		for (k = 0; k < count; k++) begin
			gap = $urandom % 3;
			repeat (gap) begin
				@(posedge clk);
				#10;
			end
			msg_data = pat[base + k][7:0];
			msg_ready = 1'b1;
			do begin
				@(posedge clk);
				#10;
			end while (!msg_rd_en);
			msg_ready = 1'b0;
		end
	endtask

	// busy rises when the last command is dispatched and falls when it completes.
	task automatic wait_idle();
		do begin
			@(posedge clk);
			#10;
		end while (!i_dut.busy);
		do begin
			@(posedge clk);
			#10;
		end while (i_dut.busy);
	endtask

	task automatic check_test(input int t, input int ring_base, input int nring,
			input int fifo_base, input int nfifo, input gpio_t exp_gpio, output int errs);
		int k;
		errs = 0;
		assert (ring_q.size() == nring) else begin
			$display("MISMATCH @%0t: test %0d wrote %0d ring bytes, expected %0d",
				$time, t, ring_q.size(), nring);
			errs++;
		end
		for (k = 0; k < nring && k < ring_q.size(); k++) begin
			assert (ring_q[k] == pat[ring_base + k][7:0]) else begin
				$display("MISMATCH @%0t: test %0d ring byte %0d is %02h, expected %02h",
					$time, t, k, ring_q[k], pat[ring_base + k][7:0]);
				errs++;
			end
		end
		assert (fifo_q.size() == nfifo) else begin
			$display("MISMATCH @%0t: test %0d wrote %0d fifo entries, expected %0d",
				$time, t, fifo_q.size(), nfifo);
			errs++;
		end
		for (k = 0; k < nfifo && k < fifo_q.size(); k++) begin
			assert (fifo_q[k] == pat[fifo_base + k][7:0]) else begin
				$display("MISMATCH @%0t: test %0d fifo length %0d is %0d, expected %0d",
					$time, t, k, fifo_q[k], pat[fifo_base + k][7:0]);
				errs++;
			end
		end
		assert (gpio == exp_gpio) else begin
			$display("MISMATCH @%0t: test %0d gpio is %02h, expected %02h",
				$time, t, gpio, exp_gpio);
			errs++;
		end
		ring_q.delete();
		fifo_q.delete();
	endtask

	initial begin
		int p;
		int t;
		int ntests;
		int total;
		int nbytes;
		int cmd_base;
		int nring;
		int ring_base;
		int nfifo;
		int fifo_base;
		int test_errs;

		clk = 1'b0;
		rst_n = 1'b0;
		msg_data = '0;
		msg_ready = 1'b0;
		systime = '0;
		errors = 0;
		failed = 0;
		limit_cycles = 0;
		void'($urandom(56841));
		$readmemh("tb/mcu_command_patterns.txt", pat);
		ntests = $isunknown(pat[0]) ? 0 : pat[0];
		if (ntests == 0) begin
			$display("ERROR: no tests could be read from tb/mcu_command_patterns.txt");
			errors++;
		end

		// command and ring bytes of all tests size the watchdog.
		total = 0;
		p = 1;
		for (t = 0; t < ntests; t++) begin
			total += pat[p];
			p += pat[p] + 2;
			total += pat[p];
			p += pat[p] + 1;
			p += pat[p] + 2;
		end
		limit_cycles = total * 40;

		repeat (4) @(posedge clk);
		#10;
		rst_n = 1'b1;

		p = 1;
		for (t = 0; t < ntests; t++) begin
			nbytes = pat[p];
			cmd_base = p + 1;
			p = cmd_base + nbytes;
			systime = pat[p];
			nring = pat[p + 1];
			ring_base = p + 2;
			p = ring_base + nring;
			nfifo = pat[p];
			fifo_base = p + 1;
			p = fifo_base + nfifo;
			send_bytes(cmd_base, nbytes);
			wait_idle();
			check_test(t + 1, ring_base, nring, fifo_base, nfifo, gpio_t'(pat[p]), test_errs);
			p = p + 1;
			errors += test_errs;
			if (test_errs != 0)
				failed++;
			$display("test %0d: %0d command bytes, %s", t + 1, nbytes,
				(test_errs == 0) ? "ok" : "FAILED");
		end

		if (i_dut.u_sva.sva_errors != 0) begin
			$display("ERROR: protocol assertions failed %0d times", i_dut.u_sva.sva_errors);
			errors += i_dut.u_sva.sva_errors;
		end
		$display("%0d tests run, %0d failed, %0d errors", ntests, failed, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("ERROR: timeout after %0d cycles, the DUT stopped responding", limit_cycles);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- tb/mcu_command_sva.sv
`timescale 1ns/1ns

module mcu_command_sva (
	input logic clk,
	input logic rst_n,
	input logic msg_rd_en,
	input logic send_ring_wr_en,
	input logic send_fifo_wr_en,
	input mcu_cmd_pkg::gpio_t gpio
);

	int sva_errors = 0; // read by the testbench at the end.

	// the decoder leaves a gap cycle after every byte it takes.
	rd_en_spaced: assert property (@(posedge clk) disable iff (!rst_n)
		msg_rd_en |=> !msg_rd_en)
		else begin
			$error("msg_rd_en high on two consecutive cycles");
			sva_errors++;
		end

	fifo_after_ring: assert property (@(posedge clk) disable iff (!rst_n)
		send_fifo_wr_en |-> $past(send_ring_wr_en))
		else begin
			$error("send_fifo_wr_en without a ring write in the cycle before");
			sva_errors++;
		end

	quiet_in_reset: assert property (@(posedge clk)
		!rst_n |-> !msg_rd_en && !send_ring_wr_en && !send_fifo_wr_en && gpio == '0)
		else begin
			$error("outputs active while rst_n is low");
			sva_errors++;
		end

endmodule

//--- logic/mcu_command.sv
`timescale 1ns/1ns

module mcu_command (
	input logic clk,
	input logic rst_n,
	input mcu_cmd_pkg::byte_t msg_data,
	input logic msg_ready,
	output logic msg_rd_en,
	output mcu_cmd_pkg::byte_t send_ring_data,
	output logic send_ring_wr_en,
	output mcu_cmd_pkg::rsp_len_t send_fifo_data,
	output logic send_fifo_wr_en,
	input mcu_cmd_pkg::arg_t systime,
	output mcu_cmd_pkg::gpio_t gpio
);
	import mcu_cmd_pkg::*;

	logic busy;
	logic cmd_valid;
	cmd_id_t cmd_id;
	logic arg_valid;
	arg_t arg_data;
	arg_idx_t nargs;
	cmd_id_t unit_cmd;
	arg_t unit_arg;
	logic sys_ready;
	logic gpio_ready;
	logic gpio_advance;
	logic sys_done;
	logic gpio_done;
	logic sys_param_write;
	arg_t sys_param;
	logic shutdown;
	logic rsp_start;
	byte_t rsp_id;
	arg_idx_t nparams;
	arg_idx_t param_idx;
	arg_t param_value;
	logic enc_done;

	vlq_decoder u_decoder (.*);

	cmd_dispatch u_dispatch (
		.sys_advance(1'b0), // system commands carry no arguments.
		.*
	);

	vlq_encoder u_encoder (.*);

	system_unit u_system (
		.cmd(unit_cmd),
		.arg_data(unit_arg),
		.cmd_ready(sys_ready),
		.cmd_done(sys_done),
		.param_data(sys_param),
		.param_write(sys_param_write),
		.*
	);

	gpio_unit u_gpio (
		.cmd(unit_cmd),
		.arg_data(unit_arg),
		.arg_advance(gpio_advance),
		.cmd_ready(gpio_ready),
		.cmd_done(gpio_done),
		.*
	);

endmodule

//--- logic/gpio_unit.sv
`timescale 1ns/1ns
`include "mcu_cmd_macros.svh"

module gpio_unit (
	input logic clk,
	input logic rst_n,
	input mcu_cmd_pkg::cmd_id_t cmd,
	input mcu_cmd_pkg::arg_t arg_data,
	output logic arg_advance,
	input logic cmd_ready,
	output logic cmd_done,
	input logic shutdown,
	output mcu_cmd_pkg::gpio_t gpio
);
	import mcu_cmd_pkg::*;

	localparam int PIN_BITS = $clog2(`MCU_NGPIO);

	logic [PIN_BITS-1:0] pin; // argument 0, latched with cmd_ready.
	gpio_t dflt; // levels taken on shutdown.
	logic shutdown_q;

	always_ff @(posedge clk) begin
		if (cmd_ready)
			pin <= arg_data[PIN_BITS-1:0];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			arg_advance <= 1'b0;
			cmd_done <= 1'b0;
			dflt <= '0;
			gpio <= '0;
			shutdown_q <= 1'b0;
		end else begin
			arg_advance <= cmd_ready;
			cmd_done <= arg_advance; // value argument is on arg_data now.
			shutdown_q <= shutdown;
			if (cmd_done && cmd == `MCU_CMD_CONFIG_DIGITAL_OUT) begin
				dflt[pin] <= arg_data[0];
				gpio[pin] <= arg_data[0];
			end else if (cmd_done && cmd == `MCU_CMD_SET_DIGITAL_OUT && !shutdown) begin
				gpio[pin] <= arg_data[0];
			end
			if (shutdown && !shutdown_q)
				gpio <= dflt;
		end
	end

endmodule

//--- logic/system_unit.sv
`timescale 1ns/1ns
`include "mcu_cmd_macros.svh"

module system_unit (
	input logic clk,
	input logic rst_n,
	input mcu_cmd_pkg::cmd_id_t cmd,
	input mcu_cmd_pkg::arg_t arg_data,
	input logic cmd_ready,
	output logic cmd_done,
	output mcu_cmd_pkg::arg_t param_data,
	output logic param_write,
	input mcu_cmd_pkg::arg_t systime,
	output logic shutdown
);
	import mcu_cmd_pkg::*;

	logic is_version;
	logic is_time;
	arg_t rsp_word; // response id shown while cmd_done is high.

	assign is_version = (cmd == `MCU_CMD_GET_VERSION);
	assign is_time = (cmd == `MCU_CMD_GET_TIME);

	// parameter goes out with cmd_ready so done can follow one cycle later.
	assign param_write = cmd_ready && (is_version || is_time);

	always_comb begin
		if (!cmd_ready)
			param_data = rsp_word;
		else if (is_time)
			param_data = systime;
		else
			param_data = `MCU_VERSION;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmd_done <= 1'b0;
			rsp_word <= '0;
			shutdown <= 1'b0;
		end else begin
			cmd_done <= cmd_ready;
			if (cmd_ready && is_time)
				rsp_word <= arg_t'(`MCU_RSP_GET_TIME);
			else if (cmd_ready)
				rsp_word <= arg_t'(`MCU_RSP_GET_VERSION);
			if (cmd_ready && cmd == `MCU_CMD_SHUTDOWN)
				shutdown <= 1'b1; // sticky until reset.
		end
	end

endmodule

//--- logic/vlq_encoder.sv
`timescale 1ns/1ns

module vlq_encoder (
	input logic clk,
	input logic rst_n,
	input logic rsp_start,
	input mcu_cmd_pkg::byte_t rsp_id,
	input mcu_cmd_pkg::arg_idx_t nparams,
	output mcu_cmd_pkg::arg_idx_t param_idx,
	input mcu_cmd_pkg::arg_t param_value,
	output mcu_cmd_pkg::byte_t send_ring_data,
	output logic send_ring_wr_en,
	output mcu_cmd_pkg::rsp_len_t send_fifo_data,
	output logic send_fifo_wr_en,
	output logic enc_done
);
	import mcu_cmd_pkg::*;

	typedef enum logic [1:0] {
		enc_idle,
		enc_size,
		enc_send,
		enc_finish
	} enc_state_t;

	enc_state_t state;
	logic [34:0] wide; // five 7-bit groups.
	logic [34:0] sr;
	logic [2:0] vlq_len;
	logic [2:0] groups; // groups left in the current parameter.
	rsp_len_t len;

	assign wide = {{3{param_value[31]}}, param_value};

	// redundant sign groups are dropped.
	always_comb begin
		if (param_value >= -32 && param_value < 96)
			vlq_len = 3'd1;
		else if (param_value >= -4096 && param_value < 12288)
			vlq_len = 3'd2;
		else if (param_value >= -524288 && param_value < 1572864)
			vlq_len = 3'd3;
		else if (param_value >= -67108864 && param_value < 201326592)
			vlq_len = 3'd4;
		else
			vlq_len = 3'd5;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= enc_idle;
			param_idx <= '0;
			sr <= '0;
			groups <= '0;
			len <= '0;
			send_ring_data <= '0;
			send_ring_wr_en <= 1'b0;
			send_fifo_data <= '0;
			send_fifo_wr_en <= 1'b0;
			enc_done <= 1'b0;
		end else begin
			send_ring_wr_en <= 1'b0;
			send_fifo_wr_en <= 1'b0;
			enc_done <= 1'b0;
			case (state)
				enc_idle: if (rsp_start) begin
					send_ring_data <= rsp_id;
					send_ring_wr_en <= 1'b1;
					len <= rsp_len_t'(1);
					param_idx <= '0;
					state <= (nparams == '0) ? enc_finish : enc_size;
				end
				enc_size: begin
					sr <= wide << (7 * (5 - vlq_len)); // first group to the top.
					groups <= vlq_len;
					state <= enc_send;
				end
				enc_send: begin
					send_ring_data <= {groups != 3'd1, sr[34:28]};
					send_ring_wr_en <= 1'b1;
					len <= len + 1'b1;
					sr <= {sr[27:0], 7'd0};
					groups <= groups - 1'b1;
					if (groups == 3'd1 && arg_idx_t'(param_idx + 1'b1) == nparams) begin
						state <= enc_finish;
					end else if (groups == 3'd1) begin
						param_idx <= param_idx + 1'b1;
						state <= enc_size;
					end
				end
				enc_finish: begin
					send_fifo_data <= len;
					send_fifo_wr_en <= 1'b1;
					enc_done <= 1'b1;
					state <= enc_idle;
				end
				default: state <= enc_idle;
			endcase
		end
	end

endmodule

//--- logic/cmd_dispatch.sv
`timescale 1ns/1ns
`include "mcu_cmd_macros.svh"

module cmd_dispatch (
	input logic clk,
	input logic rst_n,
	input logic cmd_valid,
	input mcu_cmd_pkg::cmd_id_t cmd_id,
	input logic arg_valid,
	input mcu_cmd_pkg::arg_t arg_data,
	output mcu_cmd_pkg::arg_idx_t nargs,
	output logic busy,
	output mcu_cmd_pkg::cmd_id_t unit_cmd,
	output mcu_cmd_pkg::arg_t unit_arg,
	output logic sys_ready,
	output logic gpio_ready,
	input logic sys_advance,
	input logic gpio_advance,
	input logic sys_done,
	input logic gpio_done,
	input logic sys_param_write,
	input mcu_cmd_pkg::arg_t sys_param,
	output logic rsp_start,
	output mcu_cmd_pkg::byte_t rsp_id,
	output mcu_cmd_pkg::arg_idx_t nparams,
	input mcu_cmd_pkg::arg_idx_t param_idx,
	output mcu_cmd_pkg::arg_t param_value,
	input logic enc_done
);
	import mcu_cmd_pkg::*;

	disp_state_t state;
	unit_t unit;
	unit_t tab_unit;
	arg_idx_t tab_nargs;
	logic tab_rsp;
	logic has_rsp;
	logic enc_wait; // response handed to the encoder.
	arg_idx_t arg_cnt;
	arg_idx_t arg_ptr;
	logic unit_advance;
	logic unit_done;
	arg_t args [`MCU_MAX_ARGS];
	arg_t params [`MCU_MAX_ARGS];

	// command table.
	always_comb begin
		tab_unit = unit_none;
		tab_nargs = '0;
		tab_rsp = 1'b0;
		case (cmd_id)
			`MCU_CMD_GET_VERSION, `MCU_CMD_GET_TIME: begin
				tab_unit = unit_system;
				tab_rsp = 1'b1;
			end
			`MCU_CMD_SHUTDOWN: begin
				tab_unit = unit_system;
			end
			`MCU_CMD_SET_DIGITAL_OUT, `MCU_CMD_CONFIG_DIGITAL_OUT: begin
				tab_unit = unit_gpio;
				tab_nargs = arg_idx_t'(2); // pin, value.
			end
			default: ;
		endcase
	end

	always_comb begin
		unit_advance = 1'b0;
		unit_done = 1'b0;
		case (unit)
			unit_system: begin
				unit_advance = sys_advance;
				unit_done = sys_done;
			end
			unit_gpio: begin
				unit_advance = gpio_advance;
				unit_done = gpio_done;
			end
			default: ;
		endcase
	end

	assign busy = (state == dispatch) || (state == wait_done);
	assign param_value = params[param_idx];

	always_ff @(posedge clk) begin
		if (state == collect && arg_valid)
			args[arg_cnt] <= arg_data;
		if (state == wait_done && !enc_wait && sys_param_write)
			params[nparams] <= sys_param;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= idle;
			unit <= unit_none;
			has_rsp <= 1'b0;
			enc_wait <= 1'b0;
			arg_cnt <= '0;
			arg_ptr <= '0;
			nargs <= '0;
			unit_cmd <= '0;
			unit_arg <= '0;
			sys_ready <= 1'b0;
			gpio_ready <= 1'b0;
			rsp_start <= 1'b0;
			rsp_id <= '0;
			nparams <= '0;
		end else begin
			sys_ready <= 1'b0;
			gpio_ready <= 1'b0;
			rsp_start <= 1'b0;
			case (state)
				idle: if (cmd_valid) begin
					unit_cmd <= cmd_id;
					unit <= tab_unit;
					nargs <= tab_nargs;
					has_rsp <= tab_rsp;
					arg_cnt <= '0;
					state <= (tab_nargs == '0) ? dispatch : collect;
				end
				collect: if (arg_valid) begin
					arg_cnt <= arg_cnt + 1'b1;
					if (arg_idx_t'(arg_cnt + 1'b1) == nargs)
						state <= dispatch;
				end
				dispatch: begin
					unit_arg <= args[0];
					arg_ptr <= arg_idx_t'(1);
					nparams <= '0;
					enc_wait <= 1'b0;
					sys_ready <= (unit == unit_system);
					gpio_ready <= (unit == unit_gpio);
					state <= (unit == unit_none) ? idle : wait_done;
				end
				wait_done: if (enc_wait) begin
					if (enc_done)
						state <= idle;
				end else begin
					if (sys_param_write)
						nparams <= nparams + 1'b1;
					if (unit_advance) begin
						unit_arg <= args[arg_ptr];
						arg_ptr <= arg_ptr + 1'b1;
					end
					if (unit_done && has_rsp) begin
						rsp_start <= 1'b1;
						rsp_id <= sys_param[7:0]; // id rides on param_data with done.
						enc_wait <= 1'b1;
					end else if (unit_done) begin
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

endmodule

//--- logic/vlq_decoder.sv
`timescale 1ns/1ns

module vlq_decoder (
	input logic clk,
	input logic rst_n,
	input mcu_cmd_pkg::byte_t msg_data,
	input logic msg_ready,
	output logic msg_rd_en,
	input logic busy,
	input mcu_cmd_pkg::arg_idx_t nargs,
	output logic cmd_valid,
	output mcu_cmd_pkg::cmd_id_t cmd_id,
	output logic arg_valid,
	output mcu_cmd_pkg::arg_t arg_data
);
	import mcu_cmd_pkg::*;

	arg_t acc; // groups gathered so far.
	arg_t acc_next;
	arg_idx_t arg_cnt; // arguments delivered for the current command.
	logic cont; // inside a multi-byte argument.
	logic take;
	logic expect_arg;

	// one byte every second cycle at most.
	assign take = msg_ready && !msg_rd_en && !busy;
	assign expect_arg = (arg_cnt != nargs);

	always_comb begin
		if (cont) begin
			acc_next = {acc[24:0], msg_data[6:0]};
		end else begin
			acc_next = {{25{msg_data[6] & msg_data[5]}}, msg_data[6:0]}; // 11 in bits 6:5 is negative.
		end
	end

	always_ff @(posedge clk) begin
		if (take && expect_arg)
			acc <= acc_next;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			msg_rd_en <= 1'b0;
			cmd_valid <= 1'b0;
			cmd_id <= '0;
			arg_valid <= 1'b0;
			arg_data <= '0;
			arg_cnt <= '0;
			cont <= 1'b0;
		end else begin
			msg_rd_en <= take;
			cmd_valid <= 1'b0;
			arg_valid <= 1'b0;
			if (take) begin
				if (!expect_arg) begin
					cmd_id <= msg_data[4:0];
					cmd_valid <= 1'b1;
					arg_cnt <= '0; // nargs follows from the dispatcher next cycle.
				end else begin
					cont <= msg_data[7];
					if (!msg_data[7]) begin
						arg_data <= acc_next;
						arg_valid <= 1'b1;
						arg_cnt <= arg_cnt + 1'b1;
					end
				end
			end
		end
	end

endmodule

//--- logic/mcu_cmd_pkg.sv
`include "mcu_cmd_macros.svh"

package mcu_cmd_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [4:0] cmd_id_t;
	typedef logic signed [31:0] arg_t;
	typedef logic [$clog2(`MCU_MAX_ARGS)-1:0] arg_idx_t;
	typedef logic [7:0] rsp_len_t;
	typedef logic [`MCU_NGPIO-1:0] gpio_t;

	typedef enum logic [1:0] {
		unit_none, // unknown id, dropped after decode.
		unit_system,
		unit_gpio
	} unit_t;

	typedef enum logic [1:0] {
		idle,
		collect,
		dispatch,
		wait_done // unit running, then encoder running.
	} disp_state_t;

endpackage

//--- logic/mcu_cmd_macros.svh
`ifndef MCU_CMD_MACROS_SVH
`define MCU_CMD_MACROS_SVH

// version word answered by get_version.
`define MCU_VERSION 32'h0012_3456

`define MCU_MAX_ARGS 8
`define MCU_NGPIO 8

// command ids as sent by the host.
`define MCU_CMD_GET_VERSION 5'd0
`define MCU_CMD_GET_TIME 5'd2
`define MCU_CMD_SET_DIGITAL_OUT 5'd15
`define MCU_CMD_CONFIG_DIGITAL_OUT 5'd16
`define MCU_CMD_SHUTDOWN 5'd19

// first byte of a response in the send ring.
`define MCU_RSP_GET_VERSION 8'd0
`define MCU_RSP_GET_TIME 8'd1

`endif
